// File: Bender.yml
package:
  name: exec_units

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - eu_res_pkg.sv
      - eu_op_pkg.sv
      - eu_alu.sv
      - eu_iter_seq.sv
      - eu_multiplier.sv
      - eu_divider.sv
      - eu_group_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_eu_group.sv

// File: eu_alu.sv
// integer ALU, combinational, with branch condition evaluation
`default_nettype none

`include "eu_defs.svh"

module eu_alu (
	input  eu_op_pkg::alu_op_e  op,
	input  eu_res_pkg::xdata_t  op1,
	input  eu_res_pkg::xdata_t  op2,
	output eu_res_pkg::xdata_t  res,
	output logic                brc_cond_res
);

	logic [`EU_XLEN:0] sub_ext; // extra bit is the borrow
	eu_res_pkg::xdata_t add_res;
	logic [4:0] shamt;
	logic eq;
	logic ltu;
	logic lt;

	assign add_res = op1 + op2;
	assign sub_ext = {1'b0, op1} - {1'b0, op2};
	assign shamt = op2[4:0];

	// all compares come from the one subtractor
	assign eq = (sub_ext[`EU_XLEN-1:0] == '0);
	assign ltu = sub_ext[`EU_XLEN];
	// differing signs decide directly, otherwise the borrow does
	assign lt = (op1[`EU_XLEN-1] ^ op2[`EU_XLEN-1]) ? op1[`EU_XLEN-1] : ltu;

	always_comb
	begin
		case (op)
			eu_op_pkg::ALU_ADD:  res = add_res;
			eu_op_pkg::ALU_SUB:  res = sub_ext[`EU_XLEN-1:0];
			eu_op_pkg::ALU_SLL:  res = op1 << shamt;
			eu_op_pkg::ALU_SLT:  res = {{(`EU_XLEN-1){1'b0}}, lt};
			eu_op_pkg::ALU_SLTU: res = {{(`EU_XLEN-1){1'b0}}, ltu};
			eu_op_pkg::ALU_XOR:  res = op1 ^ op2;
			eu_op_pkg::ALU_SRL:  res = op1 >> shamt;
			eu_op_pkg::ALU_SRA:  res = $signed(op1) >>> shamt;
			eu_op_pkg::ALU_OR:   res = op1 | op2;
			eu_op_pkg::ALU_AND:  res = op1 & op2;
			default:             res = '0; // branch codes give no data
		endcase
	end

	always_comb
	begin
		case (op)
			eu_op_pkg::BRC_BEQ:  brc_cond_res = eq;
			eu_op_pkg::BRC_BNE:  brc_cond_res = ~eq;
			eu_op_pkg::BRC_BLT:  brc_cond_res = lt;
			eu_op_pkg::BRC_BGE:  brc_cond_res = ~lt;
			eu_op_pkg::BRC_BLTU: brc_cond_res = ltu;
			eu_op_pkg::BRC_BGEU: brc_cond_res = ~ltu;
			default:             brc_cond_res = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: eu_defs.svh
// execution unit group widths, slot count and iteration count
`ifndef EU_DEFS_SVH
`define EU_DEFS_SVH

// instruction ID tag on the result bus
`define EU_INST_ID_W 8

// architectural data word
`define EU_XLEN 32

// operand width seen by mul/div, one extension bit above XLEN
`define EU_OPND_W 33

// destination register index
`define EU_RD_ID_W 5

// ALU, CSR, MUL, DIV
`define EU_SLOT_N 4

// one step per operand bit
`define EU_ITER_N 33

`endif

// File: eu_divider.sv
// iterative restoring divider with signed quotient/remainder correction
`default_nettype none

`include "eu_defs.svh"

module eu_divider (
	input  logic                 aclk,
	input  logic                 arst_n,
	input  eu_op_pkg::opnd_t     op_a,
	input  eu_op_pkg::opnd_t     op_b,
	input  logic                 rem_sel,
	input  eu_op_pkg::rd_id_t    rd_id,
	input  eu_res_pkg::inst_id_t inst_id,
	input  logic                 valid,
	output logic                 ready,
	output eu_res_pkg::xdata_t   res,
	output eu_op_pkg::rd_id_t    res_rd_id,
	output eu_res_pkg::inst_id_t res_inst_id,
	output logic                 res_valid
);

	localparam integer OW = `EU_OPND_W;

	eu_op_pkg::div_tag_t req_tag;
	eu_op_pkg::div_tag_t res_tag;
	logic step;
	logic start;
	logic done;

	logic [OW-1:0] a_mag;
	logic [OW-1:0] b_mag;
	logic [OW-1:0] quo; // dividend shifts out, quotient bits shift in
	logic [OW-1:0] rem;
	logic [OW-1:0] dvsr;
	logic q_neg;
	logic r_neg;
	logic [OW:0] shifted;
	logic [OW:0] diff;
	logic q_bit;
	logic [OW-1:0] q_fix;
	logic [OW-1:0] r_fix;

	assign req_tag = '{rem_sel: rem_sel, rd_id: rd_id, inst_id: inst_id};

	eu_iter_seq #(
		.tag_t(eu_op_pkg::div_tag_t),
		.STEPS(`EU_ITER_N)
	) seq_u (
		.aclk(aclk),
		.arst_n(arst_n),
		.req_valid(valid),
		.req_ready(ready),
		.req_tag(req_tag),
		.step(step),
		.start(start),
		.done(done),
		.res_tag(res_tag)
	);

	assign a_mag = op_a[OW-1] ? -op_a : op_a;
	assign b_mag = op_b[OW-1] ? -op_b : op_b;

	// trial subtract of the divisor from the partial remainder
	assign shifted = {rem, quo[OW-1]};
	assign diff = shifted - {1'b0, dvsr};
	assign q_bit = ~diff[OW];

	always_ff @(posedge aclk)
	begin
		if (start)
		begin
			quo <= a_mag;
			rem <= '0;
			dvsr <= b_mag;
			// zero divisor keeps the all-ones quotient
			q_neg <= (op_a[OW-1] ^ op_b[OW-1]) & (op_b != '0);
			r_neg <= op_a[OW-1]; // gives back the dividend when divisor is 0
		end
		else if (step)
		begin
			rem <= q_bit ? diff[OW-1:0] : shifted[OW-1:0];
			quo <= {quo[OW-2:0], q_bit};
		end
	end

	assign q_fix = q_neg ? -quo : quo;
	assign r_fix = r_neg ? -rem : rem;

	assign res = res_tag.rem_sel ? r_fix[`EU_XLEN-1:0] : q_fix[`EU_XLEN-1:0];
	assign res_rd_id = res_tag.rd_id;
	assign res_inst_id = res_tag.inst_id;
	assign res_valid = done;

endmodule

`default_nettype wire

// File: eu_group_top.sv
// execution unit group: ALU, CSR read, multiplier, divider onto one result bus
`default_nettype none

`include "eu_defs.svh"

module eu_group_top (
	input  logic                 aclk,
	input  logic                 arst_n,

	input  eu_op_pkg::alu_op_e   alu_op,
	input  eu_res_pkg::xdata_t   alu_op1,
	input  eu_res_pkg::xdata_t   alu_op2,
	input  eu_res_pkg::inst_id_t alu_tid,
	input  logic                 alu_use_res, // result written back
	input  logic                 alu_valid,
	output logic                 brc_cond_res,

	input  logic [11:0]          csr_addr,
	input  eu_res_pkg::inst_id_t csr_tid,
	input  logic                 csr_valid,
	output logic [11:0]          csr_raddr, // to external CSR file
	input  eu_res_pkg::xdata_t   csr_rdata, // old CSR value

	input  eu_op_pkg::opnd_t     mul_op_a,
	input  eu_op_pkg::opnd_t     mul_op_b,
	input  logic                 mul_res_sel,
	input  eu_op_pkg::rd_id_t    mul_rd_id,
	input  eu_res_pkg::inst_id_t mul_inst_id,
	input  logic                 mul_valid,
	output logic                 mul_ready,
	output eu_op_pkg::rd_id_t    mul_res_rd_id,

	input  eu_op_pkg::opnd_t     div_op_a,
	input  eu_op_pkg::opnd_t     div_op_b,
	input  logic                 div_rem_sel,
	input  eu_op_pkg::rd_id_t    div_rd_id,
	input  eu_res_pkg::inst_id_t div_inst_id,
	input  logic                 div_valid,
	output logic                 div_ready,
	output eu_op_pkg::rd_id_t    div_res_rd_id,

	output logic [`EU_SLOT_N-1:0]               fu_res_vld,
	output logic [`EU_SLOT_N*`EU_INST_ID_W-1:0] fu_res_tid,
	output logic [`EU_SLOT_N*`EU_XLEN-1:0]      fu_res_data
);

	eu_res_pkg::xdata_t alu_res;
	eu_res_pkg::xdata_t mul_res;
	eu_res_pkg::xdata_t div_res;
	eu_res_pkg::inst_id_t mul_res_inst_id;
	eu_res_pkg::inst_id_t div_res_inst_id;
	logic mul_res_valid;
	logic div_res_valid;

	eu_alu alu_u (
		.op(alu_op),
		.op1(alu_op1),
		.op2(alu_op2),
		.res(alu_res),
		.brc_cond_res(brc_cond_res)
	);

	assign csr_raddr = csr_addr; // combinational read through

	eu_multiplier multiplier_u (
		.aclk(aclk),
		.arst_n(arst_n),
		.op_a(mul_op_a),
		.op_b(mul_op_b),
		.res_sel(mul_res_sel),
		.rd_id(mul_rd_id),
		.inst_id(mul_inst_id),
		.valid(mul_valid),
		.ready(mul_ready),
		.res(mul_res),
		.res_rd_id(mul_res_rd_id),
		.res_inst_id(mul_res_inst_id),
		.res_valid(mul_res_valid)
	);

	eu_divider divider_u (
		.aclk(aclk),
		.arst_n(arst_n),
		.op_a(div_op_a),
		.op_b(div_op_b),
		.rem_sel(div_rem_sel),
		.rd_id(div_rd_id),
		.inst_id(div_inst_id),
		.valid(div_valid),
		.ready(div_ready),
		.res(div_res),
		.res_rd_id(div_res_rd_id),
		.res_inst_id(div_res_inst_id),
		.res_valid(div_res_valid)
	);

	// slot 0 in the low bits, order follows slot_e
	assign fu_res_vld = {div_res_valid, mul_res_valid, csr_valid, alu_valid & alu_use_res};
	assign fu_res_tid = {div_res_inst_id, mul_res_inst_id, csr_tid, alu_tid};
	assign fu_res_data = {div_res, mul_res, csr_rdata, alu_res};

endmodule

`default_nettype wire

// File: eu_iter_seq.sv
// iteration sequencer shared by the multi-cycle units: handshake, step count, tag hold
`default_nettype none

module eu_iter_seq #(
	parameter type    tag_t = logic [7:0],
	parameter integer STEPS = 8
) (
	input  logic aclk,
	input  logic arst_n,
	input  logic req_valid,
	output logic req_ready,
	input  tag_t req_tag,
	output logic step,
	output logic start,
	output logic done,
	output tag_t res_tag
);

	localparam integer CNT_W = $clog2(STEPS + 1);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic fin; // last step cycle
	logic done_q;
	logic fire;
	tag_t tag_q;

	assign fire = req_valid & req_ready;
	assign req_ready = ~busy;
	assign start = fire; // datapath loads on the accepting edge

	// cycle with cnt 0 is the load cycle, steps run at cnt 1..STEPS
	assign step = busy & (cnt != '0);
	assign fin = busy & (cnt == CNT_W'(STEPS));

	assign done = done_q;
	assign res_tag = tag_q;

	always_ff @(posedge aclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			cnt <= '0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= fin; // one-cycle pulse, busy drops at the same edge
			if (fire)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (fin)
				busy <= 1'b0;
			else if (busy)
				cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (fire)
			tag_q <= req_tag;
	end

endmodule

`default_nettype wire

// File: eu_multiplier.sv
// iterative signed 33x33 multiplier, one multiplier bit per step
`default_nettype none

`include "eu_defs.svh"

module eu_multiplier (
	input  logic                 aclk,
	input  logic                 arst_n,
	input  eu_op_pkg::opnd_t     op_a,
	input  eu_op_pkg::opnd_t     op_b,
	input  logic                 res_sel,
	input  eu_op_pkg::rd_id_t    rd_id,
	input  eu_res_pkg::inst_id_t inst_id,
	input  logic                 valid,
	output logic                 ready,
	output eu_res_pkg::xdata_t   res,
	output eu_op_pkg::rd_id_t    res_rd_id,
	output eu_res_pkg::inst_id_t res_inst_id,
	output logic                 res_valid
);

	localparam integer OW = `EU_OPND_W;
	localparam integer PW = 2 * `EU_OPND_W;

	eu_op_pkg::mul_tag_t req_tag;
	eu_op_pkg::mul_tag_t res_tag;
	logic step;
	logic start;
	logic done;

	logic [PW-1:0] acc;
	logic [PW-1:0] mcand; // sign-extended op_a
	logic [OW-1:0] mplier; // consumed msb first
	logic first; // msb step carries negative weight
	logic [PW-1:0] addend;

	assign req_tag = '{res_sel: res_sel, rd_id: rd_id, inst_id: inst_id};

	eu_iter_seq #(
		.tag_t(eu_op_pkg::mul_tag_t),
		.STEPS(`EU_ITER_N)
	) seq_u (
		.aclk(aclk),
		.arst_n(arst_n),
		.req_valid(valid),
		.req_ready(ready),
		.req_tag(req_tag),
		.step(step),
		.start(start),
		.done(done),
		.res_tag(res_tag)
	);

	assign addend = mplier[OW-1] ? (first ? -mcand : mcand) : '0;

	// acc = 2*acc +/- mcand per bit, subtract on the sign bit
	always_ff @(posedge aclk)
	begin
		if (start)
		begin
			acc <= '0;
			mcand <= {{OW{op_a[OW-1]}}, op_a};
			mplier <= op_b;
			first <= 1'b1;
		end
		else if (step)
		begin
			acc <= {acc[PW-2:0], 1'b0} + addend;
			mplier <= {mplier[OW-2:0], 1'b0};
			first <= 1'b0;
		end
	end

	assign res = res_tag.res_sel ? acc[2*`EU_XLEN-1:`EU_XLEN] : acc[`EU_XLEN-1:0];
	assign res_rd_id = res_tag.rd_id;
	assign res_inst_id = res_tag.inst_id;
	assign res_valid = done;

endmodule

`default_nettype wire

// File: eu_op_pkg.sv
// operation-side types: ALU op codes, register index, operands and mul/div tags
`default_nettype none

`include "eu_defs.svh"

package eu_op_pkg;

	// 0..9 arithmetic/logic, 10..15 branch compares
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9,
		BRC_BEQ  = 4'd10,
		BRC_BNE  = 4'd11,
		BRC_BLT  = 4'd12,
		BRC_BGE  = 4'd13,
		BRC_BLTU = 4'd14,
		BRC_BGEU = 4'd15
	} alu_op_e;

	typedef logic [`EU_RD_ID_W-1:0] rd_id_t;

	// sign or zero extension by the issuer picks signed/unsigned
	typedef logic [`EU_OPND_W-1:0] opnd_t;

	typedef struct packed {
		logic                 res_sel; // 1 selects product bits 63:32
		rd_id_t               rd_id;
		eu_res_pkg::inst_id_t inst_id;
	} mul_tag_t;

	typedef struct packed {
		logic                 rem_sel; // 1 selects remainder
		rd_id_t               rd_id;
		eu_res_pkg::inst_id_t inst_id;
	} div_tag_t;

endpackage

`default_nettype wire

// File: eu_res_pkg.sv
// result-side types of the execution unit group: ID tag, data word, slot index
`default_nettype none

`include "eu_defs.svh"

package eu_res_pkg;

	// instruction ID carried with every result
	typedef logic [`EU_INST_ID_W-1:0] inst_id_t;

	// result data word
	typedef logic [`EU_XLEN-1:0] xdata_t;

	// position of each unit on the result-return bus
	typedef enum logic [$clog2(`EU_SLOT_N)-1:0] {
		SLOT_ALU = 2'd0,
		SLOT_CSR = 2'd1,
		SLOT_MUL = 2'd2,
		SLOT_DIV = 2'd3
	} slot_e;

endpackage

`default_nettype wire

// File: exec_units.f
+incdir+.
eu_res_pkg.sv
eu_op_pkg.sv
eu_alu.sv
eu_iter_seq.sv
eu_multiplier.sv
eu_divider.sv
eu_group_top.sv
tb_eu_group.sv

// File: tb_eu_group.sv
// self-checking testbench for the execution unit group with reference models
`default_nettype none

`include "eu_defs.svh"

module tb_eu_group;

	timeunit 1ns;
	timeprecision 1ps;

	logic aclk;
	logic arst_n;
	eu_op_pkg::alu_op_e alu_op;
	eu_res_pkg::xdata_t alu_op1;
	eu_res_pkg::xdata_t alu_op2;
	eu_res_pkg::inst_id_t alu_tid;
	logic alu_use_res;
	logic alu_valid;
	logic brc_cond_res;
	logic [11:0] csr_addr;
	eu_res_pkg::inst_id_t csr_tid;
	logic csr_valid;
	logic [11:0] csr_raddr;
	eu_res_pkg::xdata_t csr_rdata;
	eu_op_pkg::opnd_t mul_op_a;
	eu_op_pkg::opnd_t mul_op_b;
	logic mul_res_sel;
	eu_op_pkg::rd_id_t mul_rd_id;
	eu_res_pkg::inst_id_t mul_inst_id;
	logic mul_valid;
	logic mul_ready;
	eu_op_pkg::rd_id_t mul_res_rd_id;
	eu_op_pkg::opnd_t div_op_a;
	eu_op_pkg::opnd_t div_op_b;
	logic div_rem_sel;
	eu_op_pkg::rd_id_t div_rd_id;
	eu_res_pkg::inst_id_t div_inst_id;
	logic div_valid;
	logic div_ready;
	eu_op_pkg::rd_id_t div_res_rd_id;
	logic [`EU_SLOT_N-1:0] fu_res_vld;
	logic [`EU_SLOT_N*`EU_INST_ID_W-1:0] fu_res_tid;
	logic [`EU_SLOT_N*`EU_XLEN-1:0] fu_res_data;

	integer seed = 66333;
	int cyc = 0; // rising edges since time zero
	logic checking;
	logic exp_alu_vld;
	eu_res_pkg::xdata_t exp_alu_data;
	eu_res_pkg::inst_id_t exp_alu_tid;
	logic exp_brc;
	logic exp_csr_vld;
	logic [11:0] exp_csr_addr;
	eu_res_pkg::xdata_t exp_csr_data;
	eu_res_pkg::inst_id_t exp_csr_tid;

	// accepted mul/div requests waiting for their result pulse
	eu_res_pkg::slot_e pend_slot[$];
	eu_res_pkg::inst_id_t pend_id[$];
	eu_res_pkg::xdata_t pend_data[$];
	eu_op_pkg::rd_id_t pend_rd[$];
	int pend_cyc[$];

	eu_group_top i_dut (.*);

	always #5 aclk = ~aclk;

	always @(posedge aclk)
		cyc <= cyc + 1;

	// external CSR file returns the address under a fixed pattern
	function automatic eu_res_pkg::xdata_t csr_value(input logic [11:0] addr);
		csr_value = {20'h0, addr} ^ 32'h5A3C_96E1;
	endfunction

	assign csr_rdata = csr_value(csr_raddr);

	function automatic eu_res_pkg::xdata_t ref_alu(input eu_op_pkg::alu_op_e op,
		input eu_res_pkg::xdata_t a, input eu_res_pkg::xdata_t b);
		case (op)
			eu_op_pkg::ALU_ADD:  ref_alu = a + b;
			eu_op_pkg::ALU_SUB:  ref_alu = a - b;
			eu_op_pkg::ALU_SLL:  ref_alu = a << b[4:0];
			eu_op_pkg::ALU_SLT:  ref_alu = ($signed(a) < $signed(b)) ? 1 : 0;
			eu_op_pkg::ALU_SLTU: ref_alu = (a < b) ? 1 : 0;
			eu_op_pkg::ALU_XOR:  ref_alu = a ^ b;
			eu_op_pkg::ALU_SRL:  ref_alu = a >> b[4:0];
			eu_op_pkg::ALU_SRA:  ref_alu = $signed(a) >>> b[4:0];
			eu_op_pkg::ALU_OR:   ref_alu = a | b;
			eu_op_pkg::ALU_AND:  ref_alu = a & b;
			default:             ref_alu = '0; // branches write no data
		endcase
	endfunction

	function automatic logic ref_brc(input eu_op_pkg::alu_op_e op,
		input eu_res_pkg::xdata_t a, input eu_res_pkg::xdata_t b);
		case (op)
			eu_op_pkg::BRC_BEQ:  ref_brc = (a == b);
			eu_op_pkg::BRC_BNE:  ref_brc = (a != b);
			eu_op_pkg::BRC_BLT:  ref_brc = ($signed(a) < $signed(b));
			eu_op_pkg::BRC_BGE:  ref_brc = ($signed(a) >= $signed(b));
			eu_op_pkg::BRC_BLTU: ref_brc = (a < b);
			eu_op_pkg::BRC_BGEU: ref_brc = (a >= b);
			default:             ref_brc = 1'b0;
		endcase
	endfunction

	function automatic eu_res_pkg::xdata_t ref_mul(input eu_op_pkg::opnd_t a,
		input eu_op_pkg::opnd_t b, input logic hi);
		logic signed [2*`EU_OPND_W-1:0] prod;
		prod = $signed(a) * $signed(b);
		ref_mul = hi ? prod[63:32] : prod[31:0];
	endfunction

	function automatic eu_res_pkg::xdata_t ref_div(input eu_op_pkg::opnd_t a,
		input eu_op_pkg::opnd_t b, input logic rem);
		logic signed [`EU_OPND_W-1:0] q;
		logic signed [`EU_OPND_W-1:0] r;
		if (b == '0)
		begin
			q = '1; // zero divisor gives all ones and the dividend back
			r = a;
		end
		else
		begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end
		ref_div = rem ? r[31:0] : q[31:0];
	endfunction

	function automatic eu_op_pkg::opnd_t extend(input eu_res_pkg::xdata_t v, input logic sgn);
		extend = {sgn & v[31], v};
	endfunction

	function automatic eu_res_pkg::xdata_t slot_data(input eu_res_pkg::slot_e s);
		slot_data = fu_res_data[s*`EU_XLEN +: `EU_XLEN];
	endfunction

	function automatic eu_res_pkg::inst_id_t slot_tid(input eu_res_pkg::slot_e s);
		slot_tid = fu_res_tid[s*`EU_INST_ID_W +: `EU_INST_ID_W];
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input eu_res_pkg::xdata_t got,
		input eu_res_pkg::xdata_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_tid(input string name, input eu_res_pkg::inst_id_t got,
		input eu_res_pkg::inst_id_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_rd_id(input string name, input eu_op_pkg::rd_id_t got,
		input eu_op_pkg::rd_id_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// result pulse must match a pending request of the same slot and ID
	task automatic check_unit(input string name, input eu_res_pkg::slot_e s,
		input logic ready, input eu_op_pkg::rd_id_t rd_got);
		int idx;
		logic busy;
		idx = -1;
		busy = 1'b0;
		foreach (pend_slot[i])
		begin
			if (pend_slot[i] == s)
			begin
				busy = 1'b1;
				if (pend_id[i] == slot_tid(s))
					idx = i;
			end
		end
		if (!fu_res_vld[s])
		begin
			if (busy)
				check_flag({name, "_ready"}, ready, 1'b0); // low while in flight
		end
		else
		begin
			if (idx < 0)
				stop_with_failure($sformatf("%s result pulse at %0t has no pending request",
					name, $time));
			check_data({name, " result"}, slot_data(s), pend_data[idx]);
			check_rd_id({name, "_res_rd_id"}, rd_got, pend_rd[idx]);
			check_flag({name, "_ready"}, ready, 1'b1);
			if (cyc - pend_cyc[idx] != 34)
				stop_with_failure($sformatf("%s result came %0d edges after acceptance, not 34",
					name, cyc - pend_cyc[idx]));
			pend_slot.delete(idx);
			pend_id.delete(idx);
			pend_data.delete(idx);
			pend_rd.delete(idx);
			pend_cyc.delete(idx);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge aclk)
	begin
		if (arst_n && checking)
		begin
			check_flag("brc_cond_res", brc_cond_res, exp_brc);
			check_flag("fu_res_vld[ALU]", fu_res_vld[eu_res_pkg::SLOT_ALU], exp_alu_vld);
			if (exp_alu_vld)
			begin
				check_data("fu_res_data[ALU]", slot_data(eu_res_pkg::SLOT_ALU), exp_alu_data);
				check_tid("fu_res_tid[ALU]", slot_tid(eu_res_pkg::SLOT_ALU), exp_alu_tid);
			end
			check_flag("fu_res_vld[CSR]", fu_res_vld[eu_res_pkg::SLOT_CSR], exp_csr_vld);
			if (exp_csr_vld)
			begin
				check_data("csr_raddr", {20'h0, csr_raddr}, {20'h0, exp_csr_addr});
				check_data("fu_res_data[CSR]", slot_data(eu_res_pkg::SLOT_CSR), exp_csr_data);
				check_tid("fu_res_tid[CSR]", slot_tid(eu_res_pkg::SLOT_CSR), exp_csr_tid);
			end
			check_unit("mul", eu_res_pkg::SLOT_MUL, mul_ready, mul_res_rd_id);
			check_unit("div", eu_res_pkg::SLOT_DIV, div_ready, div_res_rd_id);
		end
	end

	task automatic drive_alu(input eu_op_pkg::alu_op_e op, input eu_res_pkg::xdata_t a,
		input eu_res_pkg::xdata_t b, input logic use_res);
		@(posedge aclk);
		#1;
		alu_op = op;
		alu_op1 = a;
		alu_op2 = b;
		alu_tid = $random(seed);
		alu_use_res = use_res;
		alu_valid = 1'b1;
		exp_alu_vld = use_res;
		exp_alu_data = ref_alu(op, a, b);
		exp_alu_tid = alu_tid;
		exp_brc = ref_brc(op, a, b);
	endtask

	// presents a request, holds it until ready, records it after the accepting edge
	task automatic issue(input eu_res_pkg::slot_e s, input eu_op_pkg::opnd_t a,
		input eu_op_pkg::opnd_t b, input logic sel, input eu_op_pkg::rd_id_t rd,
		input eu_res_pkg::inst_id_t id);
		logic rdy;
		int n;
		if (s == eu_res_pkg::SLOT_MUL)
		begin
			mul_op_a = a;
			mul_op_b = b;
			mul_res_sel = sel;
			mul_rd_id = rd;
			mul_inst_id = id;
			mul_valid = 1'b1;
		end
		else
		begin
			div_op_a = a;
			div_op_b = b;
			div_rem_sel = sel;
			div_rd_id = rd;
			div_inst_id = id;
			div_valid = 1'b1;
		end
		rdy = 1'b0;
		for (n = 0; n < 50 && !rdy; n++)
		begin
			@(negedge aclk);
			rdy = (s == eu_res_pkg::SLOT_MUL) ? mul_ready : div_ready;
		end
		if (!rdy)
			stop_with_failure("a multiplier or divider request was never accepted");
		@(posedge aclk);
		#1;
		pend_slot.push_back(s);
		pend_id.push_back(id);
		pend_data.push_back((s == eu_res_pkg::SLOT_MUL) ? ref_mul(a, b, sel) : ref_div(a, b, sel));
		pend_rd.push_back(rd);
		pend_cyc.push_back(cyc);
	endtask

	task automatic run_mul();
		int n;
		for (n = 0; n < 24; n++)
			issue(eu_res_pkg::SLOT_MUL, extend($random(seed), n[0]), extend($random(seed), n[1]),
				n[2], $random(seed), 8'(n));
		mul_valid = 1'b0;
	endtask

	task automatic run_div();
		int n;
		eu_res_pkg::xdata_t b;
		issue(eu_res_pkg::SLOT_DIV, extend(32'h8000_0000, 1'b1), extend('1, 1'b1), 1'b0, 1, 8'h80);
		issue(eu_res_pkg::SLOT_DIV, extend(32'h8000_0000, 1'b1), extend('1, 1'b1), 1'b1, 2, 8'h81);
		issue(eu_res_pkg::SLOT_DIV, extend($random(seed), 1'b1), '0, 1'b0, 3, 8'h82);
		issue(eu_res_pkg::SLOT_DIV, extend($random(seed), 1'b1), '0, 1'b1, 4, 8'h83);
		issue(eu_res_pkg::SLOT_DIV, extend($random(seed), 1'b0), '0, 1'b1, 5, 8'h84);
		for (n = 0; n < 20; n++)
		begin
			b = (n % 5 == 0) ? '0 : $random(seed); // some zero divisors
			issue(eu_res_pkg::SLOT_DIV, extend($random(seed), n[0]), extend(b, n[0]),
				n[1], $random(seed), 8'(8'h90 + n));
		end
		div_valid = 1'b0;
	endtask

	initial
	begin
		int n;
		int k;
		eu_res_pkg::xdata_t same;
		aclk = 1'b0;
		arst_n = 1'b0;
		checking = 1'b0;
		alu_op = eu_op_pkg::ALU_ADD;
		alu_op1 = '0;
		alu_op2 = '0;
		alu_tid = '0;
		alu_use_res = 1'b0;
		alu_valid = 1'b0;
		csr_addr = '0;
		csr_tid = '0;
		csr_valid = 1'b0;
		mul_op_a = '0;
		mul_op_b = '0;
		mul_res_sel = 1'b0;
		mul_rd_id = '0;
		mul_inst_id = '0;
		mul_valid = 1'b0;
		div_op_a = '0;
		div_op_b = '0;
		div_rem_sel = 1'b0;
		div_rd_id = '0;
		div_inst_id = '0;
		div_valid = 1'b0;
		exp_alu_vld = 1'b0;
		exp_alu_data = '0;
		exp_alu_tid = '0;
		exp_brc = 1'b0;
		exp_csr_vld = 1'b0;
		exp_csr_addr = '0;
		exp_csr_data = '0;
		exp_csr_tid = '0;

		repeat (3) @(posedge aclk);
		#1;
		arst_n = 1'b1;
		@(negedge aclk);
		check_data("fu_res_vld", {{(`EU_XLEN-`EU_SLOT_N){1'b0}}, fu_res_vld}, '0);
		check_flag("mul_ready", mul_ready, 1'b1);
		check_flag("div_ready", div_ready, 1'b1);
		checking = 1'b1;

		for (n = 0; n < 300; n++)
			drive_alu(eu_op_pkg::alu_op_e'({$random(seed)} % 10), $random(seed), $random(seed),
				(n % 4) != 0);
		// branch codes on random pairs and then on equal pairs
		for (k = 10; k < 16; k++)
		begin
			for (n = 0; n < 30; n++)
				drive_alu(eu_op_pkg::alu_op_e'(k), $random(seed), $random(seed), 1'b1);
			for (n = 0; n < 5; n++)
			begin
				same = $random(seed); // used as both operands
				drive_alu(eu_op_pkg::alu_op_e'(k), same, same, 1'b1);
			end
		end

		for (n = 0; n < 20; n++)
		begin
			@(posedge aclk);
			#1;
			alu_valid = 1'b0;
			exp_alu_vld = 1'b0;
			csr_addr = $random(seed);
			csr_tid = $random(seed);
			csr_valid = (n % 3) != 2;
			exp_csr_vld = csr_valid;
			exp_csr_addr = csr_addr;
			exp_csr_tid = csr_tid;
			exp_csr_data = csr_value(csr_addr);
		end
		@(posedge aclk);
		#1;
		csr_valid = 1'b0;
		exp_csr_vld = 1'b0;

		fork
			run_mul();
			run_div();
		join

		for (n = 0; n < 100 && pend_slot.size() != 0; n++)
			@(negedge aclk);
		if (pend_slot.size() == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
			stop_with_failure("multiplier or divider results never arrived");
	end

endmodule

`default_nettype wire
